// File: ext_periph_harness.f
src/harness_pkg.sv
src/ext_addr_decode.sv
src/ext_reg_demux.sv
src/gpio_edge_counter.sv
src/powergate_switch_model.sv
src/ext_periph_harness.sv
verification/ext_periph_harness_properties.sv
verification/tb_ext_periph_harness.sv

// File: verification/tb_ext_periph_harness.sv
/*
 * Testbench for the external peripheral harness that applies a table of
 * bus accesses, GPIO pulse trains and power-switch settle checks
 */
`timescale 1ns/100ps

module tb_ext_periph_harness;

  localparam int unsigned CNT_W              = 16;
  localparam int unsigned CNT_MAX_RST        = 8;
  localparam int unsigned NUM_DOMAINS        = 4;
  localparam int unsigned SWITCH_ACK_LATENCY = 15;
  localparam int unsigned RESET_CYCLES       = 16;
  localparam int unsigned MAX_WIDTH          = 4;
  localparam int unsigned THRESH             = 5;

  localparam harness_pkg::addr_t CNT_CFG = harness_pkg::GPIO_CNT_BASE;
  localparam harness_pkg::addr_t CNT_STS = harness_pkg::GPIO_CNT_BASE + 32'h4;
  localparam harness_pkg::addr_t PG_CFG  = harness_pkg::PG_SWITCH_BASE;
  localparam harness_pkg::addr_t PG_STS  = harness_pkg::PG_SWITCH_BASE + 32'h4;
  localparam harness_pkg::data_t ALL_OFF = (1 << NUM_DOMAINS) - 1;
  localparam harness_pkg::data_t PATTERN = 32'h0000_000a;

  typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_PULSES, OP_WAIT, OP_SETTLE} op_e;

  typedef struct {
    op_e                op;
    harness_pkg::addr_t addr;
    harness_pkg::data_t data;
    int unsigned        count;
    harness_pkg::data_t exp_rdata;
    logic               exp_error;
    logic               exp_gpio;
    int unsigned        n_cnt_intr;
    int unsigned        n_pg_intr;
  } entry_t;

  logic                   clk;
  logic                   rst_n;
  logic                   reg_valid;
  logic                   reg_write;
  harness_pkg::addr_t     reg_addr;
  harness_pkg::data_t     reg_wdata;
  logic                   reg_ready;
  harness_pkg::data_t     reg_rdata;
  logic                   reg_error;
  logic                   gpio_in;
  logic                   gpio_out;
  logic [NUM_DOMAINS-1:0] pg_switch_n;
  logic [NUM_DOMAINS-1:0] pg_switch_ack_n;
  harness_pkg::intr_vec_t intr_vector;

  entry_t      table_q[$];
  int          seed;
  int unsigned cnt_intr_seen;
  int unsigned pg_intr_seen;
  int unsigned cycle_cnt;
  int unsigned cycle_limit;

  ext_periph_harness #(
    .CNT_W              (CNT_W),
    .CNT_MAX_RST        (CNT_MAX_RST),
    .NUM_DOMAINS        (NUM_DOMAINS),
    .SWITCH_ACK_LATENCY (SWITCH_ACK_LATENCY)
  ) i_ext_periph_harness (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .reg_valid_i       (reg_valid),
    .reg_write_i       (reg_write),
    .reg_addr_i        (reg_addr),
    .reg_wdata_i       (reg_wdata),
    .reg_ready_o       (reg_ready),
    .reg_rdata_o       (reg_rdata),
    .reg_error_o       (reg_error),
    .gpio_i            (gpio_in),
    .gpio_o            (gpio_out),
    .pg_switch_n_o     (pg_switch_n),
    .pg_switch_ack_n_o (pg_switch_ack_n),
    .intr_vector_o     (intr_vector)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_run();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input harness_pkg::data_t exp,
                             input harness_pkg::data_t act);
    assert (act === exp) else begin
      $display("** Error at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      stop_run();
    end
  endtask

  // Every wait goes through here so interrupt pulses are counted once
  task automatic wait_cycle();
    @(negedge clk);
    cnt_intr_seen += intr_vector[harness_pkg::INTR_GPIO_CNT];
    pg_intr_seen  += intr_vector[harness_pkg::INTR_PG_SETTLED];
  endtask

  task automatic add_entry(input op_e op, input harness_pkg::addr_t addr,
                           input harness_pkg::data_t data, input int unsigned count,
                           input harness_pkg::data_t exp_rdata, input logic exp_error,
                           input logic exp_gpio, input int unsigned n_cnt,
                           input int unsigned n_pg);
    table_q.push_back('{op, addr, data, count, exp_rdata, exp_error, exp_gpio, n_cnt, n_pg});
  endtask

  function automatic int unsigned entry_cycles(input entry_t e);
    case (e.op)
      OP_PULSES: return e.count * 2 * MAX_WIDTH;
      OP_WAIT:   return e.count;
      OP_SETTLE: return 2 * e.count;
      default:   return 1;
    endcase
  endfunction

  task automatic apply_entry(input entry_t e);
    int unsigned cnt_before;
    int unsigned pg_before;
    int unsigned width;
    int unsigned waited;

    cnt_before = cnt_intr_seen;
    pg_before  = pg_intr_seen;
    case (e.op)
      OP_WRITE, OP_READ: begin
        reg_valid = 1'b1;
        reg_write = (e.op == OP_WRITE);
        reg_addr  = e.addr;
        reg_wdata = e.data;
        #2;
        check_value("reg_ready_o", 1, reg_ready);
        check_value("reg_error_o", e.exp_error, reg_error);
        if (e.op == OP_READ || e.exp_error) begin
          check_value("reg_rdata_o", e.exp_rdata, reg_rdata);
        end
        wait_cycle();
        reg_valid = 1'b0;
        reg_write = 1'b0;
      end
      OP_PULSES: begin
        repeat (e.count) begin
          width   = 1 + ($unsigned($random(seed)) % MAX_WIDTH);
          gpio_in = 1'b1;
          repeat (width) wait_cycle();
          width   = 1 + ($unsigned($random(seed)) % MAX_WIDTH);
          gpio_in = 1'b0;
          repeat (width) wait_cycle();
        end
      end
      OP_WAIT: repeat (e.count) wait_cycle();
      OP_SETTLE: begin
        // Entered in the first cycle after the switch write
        check_value("pg_switch_n_o", e.data, pg_switch_n);
        waited = 0;
        while (pg_switch_ack_n !== e.data[NUM_DOMAINS-1:0] && waited < 2 * e.count) begin
          wait_cycle();
          waited++;
        end
        assert (pg_switch_ack_n === e.data[NUM_DOMAINS-1:0]) else begin
          $display("Switch acknowledge never reached the written pattern");
          stop_run();
        end
        check_value("pg_switch_ack_n_o latency", e.count, waited);
        check_value("intr_vector_o[INTR_PG_SETTLED]", 1,
                    intr_vector[harness_pkg::INTR_PG_SETTLED]);
      end
      default: ;
    endcase
    check_value("gpio_o", e.exp_gpio, gpio_out);
    check_value("counter interrupt pulses", e.n_cnt_intr, cnt_intr_seen - cnt_before);
    check_value("settled interrupt pulses", e.n_pg_intr, pg_intr_seen - pg_before);
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Run did not finish within %0d cycles", cycle_limit);
      stop_run();
    end
  end

  initial begin
    rst_n         = 1'b0;
    reg_valid     = 1'b0;
    reg_write     = 1'b0;
    reg_addr      = '0;
    reg_wdata     = '0;
    gpio_in       = 1'b0;
    seed          = 32'h73a1_50e2;
    cnt_intr_seen = 0;
    pg_intr_seen  = 0;
    cycle_cnt     = 0;

    // Reset values
    add_entry(OP_READ,  CNT_CFG,       32'h0, 0, CNT_MAX_RST, 1'b0, 1'b0, 0, 0);
    add_entry(OP_READ,  PG_STS,        32'h0, 0, ALL_OFF,     1'b0, 1'b0, 0, 0);
    add_entry(OP_READ,  CNT_STS,       32'h0, 0, 32'h0,       1'b0, 1'b0, 0, 0);
    // Unmapped addresses leave the peripherals alone
    add_entry(OP_WRITE, 32'h2000_2000, 32'h3, 0, 32'h0,       1'b1, 1'b0, 0, 0);
    add_entry(OP_WRITE, 32'h1fff_fff0, 32'h0, 0, 32'h0,       1'b1, 1'b0, 0, 0);
    add_entry(OP_READ,  32'h0000_0004, 32'h0, 0, 32'h0,       1'b1, 1'b0, 0, 0);
    add_entry(OP_READ,  32'h2000_2004, 32'h0, 0, 32'h0,       1'b1, 1'b0, 0, 0);
    add_entry(OP_READ,  CNT_CFG,       32'h0, 0, CNT_MAX_RST, 1'b0, 1'b0, 0, 0);
    add_entry(OP_READ,  PG_CFG,        32'h0, 0, ALL_OFF,     1'b0, 1'b0, 0, 0);
    add_entry(OP_READ,  32'h2000_0008, 32'h0, 0, 32'h0,       1'b0, 1'b0, 0, 0);
    // Counting below and up to the threshold
    add_entry(OP_WRITE, CNT_CFG,       THRESH, 0, 32'h0,      1'b0, 1'b0, 0, 0);
    add_entry(OP_PULSES, '0,           32'h0, THRESH - 2, 32'h0, 1'b0, 1'b0, 0, 0);
    add_entry(OP_READ,  CNT_STS,       32'h0, 0, THRESH - 2,  1'b0, 1'b0, 0, 0);
    add_entry(OP_PULSES, '0,           32'h0, 2, 32'h0,       1'b0, 1'b1, 1, 0);
    add_entry(OP_READ,  CNT_STS,       32'h0, 0, 32'h0,       1'b0, 1'b1, 0, 0);
    // Power switch pattern and its delayed acknowledge
    add_entry(OP_WRITE, PG_CFG,        PATTERN, 0, 32'h0,     1'b0, 1'b1, 0, 0);
    add_entry(OP_SETTLE, PG_CFG,       PATTERN, SWITCH_ACK_LATENCY, 32'h0, 1'b0, 1'b1, 0, 1);
    add_entry(OP_READ,  PG_STS,        32'h0, 0, PATTERN,     1'b0, 1'b1, 0, 0);
    add_entry(OP_WRITE, PG_STS,        32'h0, 0, 32'h0,       1'b0, 1'b1, 0, 0);
    add_entry(OP_WAIT,  '0,            32'h0, 5, 32'h0,       1'b0, 1'b1, 0, 0);
    add_entry(OP_READ,  PG_CFG,        32'h0, 0, PATTERN,     1'b0, 1'b1, 0, 0);

    cycle_limit = RESET_CYCLES + 100;
    foreach (table_q[i]) begin
      cycle_limit += entry_cycles(table_q[i]);
    end

    repeat (RESET_CYCLES) wait_cycle();
    rst_n = 1'b1;
    check_value("gpio_o", 0, gpio_out);
    check_value("intr_vector_o", 0, intr_vector);
    check_value("pg_switch_n_o", ALL_OFF, pg_switch_n);

    foreach (table_q[i]) begin
      apply_entry(table_q[i]);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: verification/ext_periph_harness_properties.sv
/*
 * Bus, interrupt and switch acknowledge properties of the harness top level
 */
`timescale 1ns/100ps

module ext_periph_harness_properties #(
  parameter int unsigned NUM_DOMAINS        = 4,
  parameter int unsigned SWITCH_ACK_LATENCY = 15
) (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   reg_valid_i,
  input logic                   reg_ready_i,
  input harness_pkg::intr_vec_t intr_vector_i,
  input logic [NUM_DOMAINS-1:0] pg_switch_n_i,
  input logic [NUM_DOMAINS-1:0] pg_switch_ack_n_i
);

  // No back-pressure on the register bus
  ready_with_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) reg_valid_i |-> reg_ready_i
  ) else $error("reg_ready_o low during a request");

  for (genvar b = 0; b < harness_pkg::INTR_W; b++) begin : g_intr
    intr_one_cycle: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) intr_vector_i[b] |=> !intr_vector_i[b]
    ) else $error("Interrupt bit %0d high for more than one cycle", b);
  end

  // Acknowledge is the switch vector seen through the delay line
  ack_latency: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      pg_switch_ack_n_i == $past(pg_switch_n_i, SWITCH_ACK_LATENCY)
  ) else $error("pg_switch_ack_n_o does not follow pg_switch_n_o");

endmodule

bind ext_periph_harness ext_periph_harness_properties #(
  .NUM_DOMAINS        (NUM_DOMAINS),
  .SWITCH_ACK_LATENCY (SWITCH_ACK_LATENCY)
) i_ext_periph_harness_properties (
  .clk_i             (clk_i),
  .rst_n_i           (rst_n_i),
  .reg_valid_i       (reg_valid_i),
  .reg_ready_i       (reg_ready_o),
  .intr_vector_i     (intr_vector_o),
  .pg_switch_n_i     (pg_switch_n_o),
  .pg_switch_ack_n_i (pg_switch_ack_n_o)
);

// File: src/ext_periph_harness.sv
/*
 * External peripheral harness: register bus decode and demux in front
 * of the GPIO counter and the power-switch model, plus interrupt vector
 */
`timescale 1ns/100ps

module ext_periph_harness #(
  parameter int unsigned CNT_W              = 16,
  parameter int unsigned CNT_MAX_RST        = 8,
  parameter int unsigned NUM_DOMAINS        = 4,
  parameter int unsigned SWITCH_ACK_LATENCY = 15
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // Host register bus
  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  harness_pkg::addr_t     reg_addr_i,
  input  harness_pkg::data_t     reg_wdata_i,
  output logic                   reg_ready_o,
  output harness_pkg::data_t     reg_rdata_o,
  output logic                   reg_error_o,

  // Pins
  input  logic                   gpio_i,
  output logic                   gpio_o,
  output logic [NUM_DOMAINS-1:0] pg_switch_n_o,
  output logic [NUM_DOMAINS-1:0] pg_switch_ack_n_o,

  output harness_pkg::intr_vec_t intr_vector_o
);

  harness_pkg::periph_idx_t sel_idx;
  logic                     sel_hit;

  logic                     cnt_valid;
  logic                     pg_valid;
  logic                     periph_write;
  harness_pkg::reg_ofs_t    periph_ofs;
  harness_pkg::data_t       periph_wdata;
  harness_pkg::data_t       cnt_rdata;
  harness_pkg::data_t       pg_rdata;

  logic                     cnt_intr;
  logic                     pg_settled_intr;

  ext_addr_decode i_ext_addr_decode (
    .addr_i    (reg_addr_i),
    .sel_idx_o (sel_idx),
    .sel_hit_o (sel_hit)
  );

  ext_reg_demux i_ext_reg_demux (
    .reg_valid_i    (reg_valid_i),
    .reg_write_i    (reg_write_i),
    .reg_addr_i     (reg_addr_i),
    .reg_wdata_i    (reg_wdata_i),
    .reg_ready_o    (reg_ready_o),
    .reg_rdata_o    (reg_rdata_o),
    .reg_error_o    (reg_error_o),
    .sel_idx_i      (sel_idx),
    .sel_hit_i      (sel_hit),
    .cnt_valid_o    (cnt_valid),
    .pg_valid_o     (pg_valid),
    .periph_write_o (periph_write),
    .periph_ofs_o   (periph_ofs),
    .periph_wdata_o (periph_wdata),
    .cnt_rdata_i    (cnt_rdata),
    .pg_rdata_i     (pg_rdata)
  );

  gpio_edge_counter #(
    .CNT_W       (CNT_W),
    .CNT_MAX_RST (CNT_MAX_RST)
  ) i_gpio_edge_counter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (cnt_valid),
    .write_i    (periph_write),
    .ofs_i      (periph_ofs),
    .wdata_i    (periph_wdata),
    .rdata_o    (cnt_rdata),
    .gpio_i     (gpio_i),
    .gpio_o     (gpio_o),
    .cnt_intr_o (cnt_intr)
  );

  powergate_switch_model #(
    .NUM_DOMAINS        (NUM_DOMAINS),
    .SWITCH_ACK_LATENCY (SWITCH_ACK_LATENCY)
  ) i_powergate_switch_model (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .valid_i           (pg_valid),
    .write_i           (periph_write),
    .ofs_i             (periph_ofs),
    .wdata_i           (periph_wdata),
    .rdata_o           (pg_rdata),
    .pg_switch_n_o     (pg_switch_n_o),
    .pg_switch_ack_n_o (pg_switch_ack_n_o),
    .pg_settled_intr_o (pg_settled_intr)
  );

  // Unused lines stay low
  always_comb begin
    intr_vector_o = '0;
    intr_vector_o[harness_pkg::INTR_GPIO_CNT]   = cnt_intr;
    intr_vector_o[harness_pkg::INTR_PG_SETTLED] = pg_settled_intr;
  end

endmodule

// File: src/powergate_switch_model.sv
/*
 * Power-switch model: per-domain active-low switch controls, with the
 * switch cells modelled as a fixed-latency acknowledge delay line
 */
`timescale 1ns/100ps

module powergate_switch_model #(
  parameter int unsigned NUM_DOMAINS        = 4,
  parameter int unsigned SWITCH_ACK_LATENCY = 15
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // Register port
  input  logic                   valid_i,
  input  logic                   write_i,
  input  harness_pkg::reg_ofs_t  ofs_i,
  input  harness_pkg::data_t     wdata_i,
  output harness_pkg::data_t     rdata_o,

  output logic [NUM_DOMAINS-1:0] pg_switch_n_o,
  output logic [NUM_DOMAINS-1:0] pg_switch_ack_n_o,
  output logic                   pg_settled_intr_o
);

  typedef logic [NUM_DOMAINS-1:0] dom_vec_t;

  logic     cfg_wr;
  dom_vec_t switch_n_q;
  dom_vec_t ack_pipe_q [SWITCH_ACK_LATENCY];
  dom_vec_t ack_n;
  logic     ack_match;
  logic     pending_q;

  assign cfg_wr = valid_i & write_i & (ofs_i == harness_pkg::OFS_CFG);

  // Switch controls, all domains off out of reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      switch_n_q <= '1;
    end else if (cfg_wr) begin
      switch_n_q <= wdata_i[NUM_DOMAINS-1:0];
    end
  end

  // Stage 0 holds the controls of the previous cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int unsigned i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        ack_pipe_q[i] <= '1;
      end
    end else begin
      ack_pipe_q[0] <= switch_n_q;
      for (int unsigned i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        ack_pipe_q[i] <= ack_pipe_q[i-1];
      end
    end
  end

  assign ack_n = ack_pipe_q[SWITCH_ACK_LATENCY-1];

  // Remember a mismatch so the settle pulse fires only once
  assign ack_match = (ack_n == switch_n_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= ~ack_match;
    end
  end

  assign pg_settled_intr_o = ack_match & pending_q;

  assign pg_switch_n_o     = switch_n_q;
  assign pg_switch_ack_n_o = ack_n;

  always_comb begin
    case (ofs_i)
      harness_pkg::OFS_CFG:    rdata_o = harness_pkg::data_t'(switch_n_q);
      harness_pkg::OFS_STATUS: rdata_o = harness_pkg::data_t'(ack_n);
      default:                 rdata_o = '0;
    endcase
  end

endmodule

// File: src/gpio_edge_counter.sv
/*
 * GPIO edge counter: counts rising edges on the input pin up to a
 * programmable threshold, then toggles the output pin and interrupts
 */
`timescale 1ns/100ps

module gpio_edge_counter #(
  parameter int unsigned CNT_W       = 16,
  parameter int unsigned CNT_MAX_RST = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Register port
  input  logic                  valid_i,
  input  logic                  write_i,
  input  harness_pkg::reg_ofs_t ofs_i,
  input  harness_pkg::data_t    wdata_i,
  output harness_pkg::data_t    rdata_o,

  input  logic                  gpio_i,
  output logic                  gpio_o,
  output logic                  cnt_intr_o
);

  typedef logic [CNT_W-1:0] cnt_t;

  logic gpio_q;
  logic gpio_prev_q;
  logic rise;
  logic cfg_wr;
  logic fire;
  cnt_t thresh_q;
  cnt_t cnt_q;
  cnt_t cnt_inc;
  logic gpio_out_q;
  logic cnt_intr_q;

  assign cfg_wr  = valid_i & write_i & (ofs_i == harness_pkg::OFS_CFG);
  assign rise    = gpio_q & ~gpio_prev_q;
  assign cnt_inc = cnt_q + cnt_t'(1);

  // A register write takes priority over a coincident edge
  assign fire = rise & (cnt_inc == thresh_q) & ~cfg_wr;

  // Input register and edge history
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_q      <= 1'b0;
      gpio_prev_q <= 1'b0;
    end else begin
      gpio_q      <= gpio_i;
      gpio_prev_q <= gpio_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      thresh_q <= cnt_t'(CNT_MAX_RST);
      cnt_q    <= '0;
    end else if (cfg_wr) begin
      thresh_q <= wdata_i[CNT_W-1:0];
      cnt_q    <= '0;
    end else if (fire) begin
      cnt_q <= '0;
    end else if (rise) begin
      cnt_q <= cnt_inc;
    end
  end

  // Toggle and interrupt appear together with the cleared count
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_out_q <= 1'b0;
      cnt_intr_q <= 1'b0;
    end else begin
      cnt_intr_q <= fire;
      if (fire) begin
        gpio_out_q <= ~gpio_out_q;
      end
    end
  end

  assign gpio_o     = gpio_out_q;
  assign cnt_intr_o = cnt_intr_q;

  always_comb begin
    case (ofs_i)
      harness_pkg::OFS_CFG:    rdata_o = harness_pkg::data_t'(thresh_q);
      harness_pkg::OFS_STATUS: rdata_o = harness_pkg::data_t'(cnt_q);
      default:                 rdata_o = '0;
    endcase
  end

endmodule

// File: src/ext_reg_demux.sv
/*
 * Register bus demultiplexer: forwards a request to the selected
 * peripheral and returns its read data, or an error if unmapped
 */
`timescale 1ns/100ps

module ext_reg_demux (
  // Host side
  input  logic                     reg_valid_i,
  input  logic                     reg_write_i,
  input  harness_pkg::addr_t       reg_addr_i,
  input  harness_pkg::data_t       reg_wdata_i,
  output logic                     reg_ready_o,
  output harness_pkg::data_t       reg_rdata_o,
  output logic                     reg_error_o,

  // From the address decoder
  input  harness_pkg::periph_idx_t sel_idx_i,
  input  logic                     sel_hit_i,

  // Peripheral side
  output logic                     cnt_valid_o,
  output logic                     pg_valid_o,
  output logic                     periph_write_o,
  output harness_pkg::reg_ofs_t    periph_ofs_o,
  output harness_pkg::data_t       periph_wdata_o,
  input  harness_pkg::data_t       cnt_rdata_i,
  input  harness_pkg::data_t       pg_rdata_i
);

  logic req_hit;

  assign req_hit = reg_valid_i & sel_hit_i;

  // Only the addressed peripheral sees the request
  assign cnt_valid_o = req_hit & (sel_idx_i == harness_pkg::GPIO_CNT_IDX);
  assign pg_valid_o  = req_hit & (sel_idx_i == harness_pkg::PG_SWITCH_IDX);

  assign periph_write_o = reg_write_i;
  assign periph_ofs_o   = reg_addr_i[harness_pkg::REG_OFS_W-1:0];
  assign periph_wdata_o = reg_wdata_i;

  // No back-pressure, every request completes in its own cycle
  assign reg_ready_o = reg_valid_i;
  assign reg_error_o = reg_valid_i & ~sel_hit_i;

  always_comb begin
    reg_rdata_o = '0;
    if (req_hit) begin
      case (sel_idx_i)
        harness_pkg::GPIO_CNT_IDX:  reg_rdata_o = cnt_rdata_i;
        harness_pkg::PG_SWITCH_IDX: reg_rdata_o = pg_rdata_i;
        default:                    reg_rdata_o = '0;
      endcase
    end
  end

endmodule

// File: src/ext_addr_decode.sv
/*
 * Address decoder for the external peripheral regions: returns the
 * index of the region holding the address and a match flag
 */
`timescale 1ns/100ps

module ext_addr_decode (
  input  harness_pkg::addr_t       addr_i,
  output harness_pkg::periph_idx_t sel_idx_o,
  output logic                     sel_hit_o
);

  always_comb begin
    harness_pkg::addr_t rel_addr;

    sel_idx_o = '0;
    sel_hit_o = 1'b0;
    rel_addr  = '0;

    // Walk the region table, the last matching entry wins
    for (int unsigned i = 0; i < harness_pkg::NPERIPH; i++) begin
      // Below the base wraps to a large value and fails the span check
      rel_addr = addr_i - harness_pkg::PERIPH_BASE[i];
      if (rel_addr < harness_pkg::PERIPH_SPAN) begin
        sel_idx_o = harness_pkg::periph_idx_t'(i);
        sel_hit_o = 1'b1;
      end
    end
  end

endmodule

// File: src/harness_pkg.sv
/*
 * External peripheral harness package: bus widths, address map,
 * register offsets and interrupt bit positions
 */
package harness_pkg;

  // Register bus
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Peripheral indices
  localparam int unsigned NPERIPH = 2;

  typedef logic [0:0] periph_idx_t;

  localparam periph_idx_t GPIO_CNT_IDX  = 1'b0;
  localparam periph_idx_t PG_SWITCH_IDX = 1'b1;

  // Address map, one 4 KiB region per peripheral
  localparam addr_t GPIO_CNT_BASE  = 32'h2000_0000;
  localparam addr_t PG_SWITCH_BASE = 32'h2000_1000;
  localparam addr_t PERIPH_SPAN    = 32'h0000_1000;

  // Region bases, entry i belongs to peripheral index i
  localparam addr_t [NPERIPH-1:0] PERIPH_BASE = {
    PG_SWITCH_BASE,
    GPIO_CNT_BASE
  };

  // Register offsets inside a region
  localparam int unsigned REG_OFS_W = 4;

  typedef logic [REG_OFS_W-1:0] reg_ofs_t;

  localparam reg_ofs_t OFS_CFG    = 4'h0;
  localparam reg_ofs_t OFS_STATUS = 4'h4;

  // External interrupt lines
  localparam int unsigned INTR_W = 2;

  typedef logic [INTR_W-1:0] intr_vec_t;

  localparam int unsigned INTR_GPIO_CNT   = 0;
  localparam int unsigned INTR_PG_SETTLED = 1;

endpackage
